//--- build.f
logic/complexFirPkg.sv
logic/firCoeffLoader.sv
logic/complexFirCore.sv
logic/firWishboneSlave.sv
logic/complexFirTop.sv
dv/complexFir_checker.sv
dv/complexFirTb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the simulation prints the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module complexFirTb -o complexFirSim &&
./obj_dir/complexFirSim | tee /dev/stderr | grep -qx "TEST RESULT: PASS" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }

//--- dv/complexFirTb.sv
`timescale 1ns/10ps

module complexFirTb;

	logic clock;
	logic reset;
	logic cyc;
	logic stb;
	logic we;
	logic [complexFirPkg::addrWidth-1:0] adr;
	logic [complexFirPkg::busWidth-1:0] datIn;
	logic [complexFirPkg::busWidth-1:0] datOut;
	logic ack;

	// Reference delay line with the newest accepted sample in slot 0.
	longint modelRe [complexFirPkg::tapCount];
	longint modelIm [complexFirPkg::tapCount];
	logic [31:0] rngState;
	logic [31:0] readValue;
	int checkCount;
	int errorCount;
	int testCount;
	int failedTests;
	int errorsAtTestStart;

	complexFirTop u_dut (.*);

	always #4 clock = ~clock;

	// The budget is 400 samples of tapCount + 30 cycles at 8 ns with a factor of two in hand.
	initial begin
		#(400 * (complexFirPkg::tapCount + 30) * 8 * 2);
		$display("Timeout: the run did not finish in time, a transfer or a result never came.");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	function automatic logic [31:0] nextRandom(input logic [31:0] value);
		logic [31:0] x;
		x = value ^ (value << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// One Wishbone classic cycle; the strobe drops on the falling edge where ack is seen.
	task automatic busCycle(input logic write, input logic [2:0] address, input logic [31:0] data);
		int waited;
		@(negedge clock);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = address;
		datIn = data;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!ack && waited < 16);
		if (!ack) begin
			$display("No ack came for the transfer to address %0d at %0t ns.", address, $time);
			errorCount++;
		end
		readValue = datOut;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic compareWord(input string name, input logic [31:0] expected);
		checkCount++;
		if (readValue !== expected) begin
			$display("[ERROR] %0t ns: %s expected 0x%08h, actual 0x%08h",
				$time, name, expected, readValue);
			errorCount++;
		end
	endtask

	// Polls status until the masked bits match, giving up after a bounded number of reads.
	task automatic pollStatus(input logic [31:0] mask, input logic [31:0] want, input string what);
		int polls;
		polls = 0;
		do begin
			busCycle(1'b0, complexFirPkg::regStatus, '0);
			polls++;
		end while ((readValue & mask) != want && polls < 64);
		if ((readValue & mask) != want) begin
			$display("Status never showed %s, stopped polling at %0t ns.", what, $time);
			errorCount++;
		end
	endtask

	// Accepted samples shift the model line; the complex dot product then gives both parts.
	task automatic pushAndCheck(input logic [31:0] data);
		longint expRe;
		longint expIm;
		for (int i = complexFirPkg::tapCount - 1; i > 0; i--) begin
			modelRe[i] = modelRe[i - 1];
			modelIm[i] = modelIm[i - 1];
		end
		modelRe[0] = longint'($signed(data[7:0]));
		modelIm[0] = longint'($signed(data[15:8]));
		pollStatus(32'h6, 32'h4, "busy low with resultValid high");
		expRe = 0;
		expIm = 0;
		for (int k = 0; k < complexFirPkg::tapCount; k++) begin
			expRe += longint'(complexFirPkg::coeffTableRe[k]) * modelRe[k]
				- longint'(complexFirPkg::coeffTableIm[k]) * modelIm[k];
			expIm += longint'(complexFirPkg::coeffTableRe[k]) * modelIm[k]
				+ longint'(complexFirPkg::coeffTableIm[k]) * modelRe[k];
		end
		busCycle(1'b0, complexFirPkg::regResultRe, '0);
		compareWord("resultRe", 32'(expRe));
		busCycle(1'b0, complexFirPkg::regResultIm, '0);
		compareWord("resultIm", 32'(expIm));
	endtask

	task automatic randomSample();
		rngState = nextRandom(rngState);
		busCycle(1'b1, complexFirPkg::regSample, rngState);
		pushAndCheck(rngState);
	endtask

	// A load empties the DUT history, so the model line restarts from zero as well.
	task automatic loadCoefficients();
		busCycle(1'b1, complexFirPkg::regControl, 32'h1);
		modelRe = '{default: 0};
		modelIm = '{default: 0};
		pollStatus(32'h1, 32'h1, "coeffReady high");
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount == errorsAtTestStart) begin
			$display("Test %0d (%s) passed.", testCount, name);
		end else begin
			failedTests++;
			$display("Test %0d (%s) failed with %0d errors.", testCount, name,
				errorCount - errorsAtTestStart);
		end
		errorsAtTestStart = errorCount;
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		datIn = '0;
		rngState = 32'h4848_6b14;
		checkCount = 0;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		errorsAtTestStart = 0;
		repeat (5) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		busCycle(1'b0, complexFirPkg::regStatus, '0);
		compareWord("status", 32'h0);
		busCycle(1'b0, complexFirPkg::regResultRe, '0);
		compareWord("resultRe", 32'h0);
		busCycle(1'b0, complexFirPkg::regResultIm, '0);
		compareWord("resultIm", 32'h0);
		busCycle(1'b0, complexFirPkg::regControl, '0);
		compareWord("control", 32'h0);
		finishTest("reset values");

		loadCoefficients();
		busCycle(1'b1, complexFirPkg::regControl, 32'h0);
		busCycle(1'b0, complexFirPkg::regStatus, '0);
		compareWord("status", 32'h0);
		finishTest("coefficient ready flag");

		loadCoefficients();
		repeat (300) randomSample();
		finishTest("random samples");

		// The second write lands while the MAC runs, so the model never sees it.
		rngState = nextRandom(rngState);
		busCycle(1'b1, complexFirPkg::regSample, rngState);
		busCycle(1'b1, complexFirPkg::regSample, nextRandom(rngState));
		pushAndCheck(rngState);
		rngState = nextRandom(nextRandom(rngState));
		randomSample();
		finishTest("write while busy");

		// With the enable low the core is empty and ignores the sample.
		// Status then shows coeffReady and busy low while the last result stays valid.
		busCycle(1'b1, complexFirPkg::regControl, 32'h0);
		busCycle(1'b1, complexFirPkg::regSample, 32'h0000_7f7f);
		busCycle(1'b0, complexFirPkg::regStatus, '0);
		compareWord("status", 32'h4);
		loadCoefficients();
		repeat (100) randomSample();
		finishTest("reload clears history");

		$display("Tests %0d, failed %0d, checks %0d, errors %0d.",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- dv/complexFir_checker.sv
`timescale 1ns/10ps

module complexFir_checker (
	input logic clock,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic busy,
	input logic coeffSetFlag,
	input logic resultValid
);

	// An ack only ever answers a request seen on the previous edge.
	ackAfterRequest: assert property (@(posedge clock) disable iff (reset)
		ack |-> $past(cyc && stb))
		else $error("ack rose without cyc and stb in the cycle before");

	// Classic Wishbone here has exactly one ack cycle per transfer.
	ackSingleCycle: assert property (@(posedge clock) disable iff (reset) ack |=> !ack)
		else $error("ack stayed high for two cycles");

	// The MAC can only run on a complete coefficient set.
	busyNeedsCoeffs: assert property (@(posedge clock) disable iff (reset) busy |-> coeffSetFlag)
		else $error("busy while the coefficient set flag is low");

	// A result is never valid while the next one is being computed.
	busyExcludesValid: assert property (@(posedge clock) disable iff (reset)
		!(busy && resultValid))
		else $error("busy and resultValid high together");

endmodule

bind complexFirTop complexFir_checker u_checker (
	.clock(clock),
	.reset(reset),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.busy(busy),
	.coeffSetFlag(coeffSetFlag),
	.resultValid(resultValid)
);

//--- logic/complexFirTop.sv
`timescale 1ns/10ps

module complexFirTop (
	input logic clock,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [complexFirPkg::addrWidth-1:0] adr,
	input logic [complexFirPkg::busWidth-1:0] datIn,
	output logic [complexFirPkg::busWidth-1:0] datOut,
	output logic ack
);

	// Slave to loader and core.
	logic loadEnable;
	logic sampleStrobe;
	logic signed [complexFirPkg::sampleWidth-1:0] sampleRe;
	logic signed [complexFirPkg::sampleWidth-1:0] sampleIm;

	// Loader to core; the flag also goes to the status register.
	logic coeffValid;
	logic signed [complexFirPkg::coeffWidth-1:0] coeffRe;
	logic signed [complexFirPkg::coeffWidth-1:0] coeffIm;
	logic coeffSetFlag;

	// Core to slave.
	logic busy;
	logic resultValid;
	logic signed [complexFirPkg::accWidth-1:0] resultRe;
	logic signed [complexFirPkg::accWidth-1:0] resultIm;

	firWishboneSlave u_slave (
		.clock(clock),
		.reset(reset),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datIn(datIn),
		.datOut(datOut),
		.ack(ack),
		.loadEnable(loadEnable),
		.sampleStrobe(sampleStrobe),
		.sampleRe(sampleRe),
		.sampleIm(sampleIm),
		.coeffSetFlag(coeffSetFlag),
		.busy(busy),
		.resultValid(resultValid),
		.resultRe(resultRe),
		.resultIm(resultIm)
	);

	firCoeffLoader u_loader (
		.clock(clock),
		.reset(reset),
		.loadEnable(loadEnable),
		.coeffValid(coeffValid),
		.coeffRe(coeffRe),
		.coeffIm(coeffIm),
		.coeffSetFlag(coeffSetFlag)
	);

	complexFirCore u_core (
		.clock(clock),
		.reset(reset),
		.loadEnable(loadEnable),
		.coeffValid(coeffValid),
		.coeffRe(coeffRe),
		.coeffIm(coeffIm),
		.coeffSetFlag(coeffSetFlag),
		.sampleStrobe(sampleStrobe),
		.sampleRe(sampleRe),
		.sampleIm(sampleIm),
		.busy(busy),
		.resultValid(resultValid),
		.resultRe(resultRe),
		.resultIm(resultIm)
	);

endmodule

//--- logic/firWishboneSlave.sv
`timescale 1ns/10ps

module firWishboneSlave (
	input logic clock,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic we,
	input logic [complexFirPkg::addrWidth-1:0] adr,
	input logic [complexFirPkg::busWidth-1:0] datIn,
	output logic [complexFirPkg::busWidth-1:0] datOut,
	output logic ack,
	output logic loadEnable,
	output logic sampleStrobe,
	output logic signed [complexFirPkg::sampleWidth-1:0] sampleRe,
	output logic signed [complexFirPkg::sampleWidth-1:0] sampleIm,
	input logic coeffSetFlag,
	input logic busy,
	input logic resultValid,
	input logic signed [complexFirPkg::accWidth-1:0] resultRe,
	input logic signed [complexFirPkg::accWidth-1:0] resultIm
);

	// First cycle of a transfer; ack in the cycle after masks the rest of it.
	logic request;

	// Write decodes for the two writable registers.
	logic controlWrite;
	logic sampleWrite;

	// Read value for the addressed register.
	logic [complexFirPkg::busWidth-1:0] readData;

	assign request = cyc && stb && !ack;
	assign controlWrite = request && we && (adr == complexFirPkg::regControl);
	assign sampleWrite = request && we && (adr == complexFirPkg::regSample);

	// Read decode.
	// Results are signed, so the casts sign-extend them to the bus width.
	always_comb begin
		case (adr)
			complexFirPkg::regControl: begin
				readData = {{(complexFirPkg::busWidth - 1){1'b0}}, loadEnable};
			end
			complexFirPkg::regStatus: begin
				readData = {{(complexFirPkg::busWidth - 3){1'b0}}, resultValid, busy, coeffSetFlag};
			end
			complexFirPkg::regResultRe: begin
				readData = complexFirPkg::busWidth'(resultRe);
			end
			complexFirPkg::regResultIm: begin
				readData = complexFirPkg::busWidth'(resultIm);
			end
			default: begin
				// Unmapped addresses and the write-only sample register read zero.
				readData = '0;
			end
		endcase
	end

	// Handshake and control state.
	always_ff @(posedge clock) begin
		if (reset) begin
			ack <= 1'b0;
			loadEnable <= 1'b0;
			sampleStrobe <= 1'b0;
		end else begin
			ack <= request;
			// The pulse comes with the ack; the core decides on its own whether to take it.
			sampleStrobe <= sampleWrite;
			if (controlWrite) begin
				loadEnable <= datIn[0];
			end
		end
	end

	// Sample parts are captured together with the strobe.
	always_ff @(posedge clock) begin
		if (sampleWrite) begin
			sampleRe <= datIn[complexFirPkg::sampleWidth-1:0];
			sampleIm <= datIn[2*complexFirPkg::sampleWidth-1:complexFirPkg::sampleWidth];
		end
	end

	// Read data is registered so it is valid while ack is high.
	// Writes return zero.
	always_ff @(posedge clock) begin
		if (request) begin
			datOut <= we ? '0 : readData;
		end
	end

endmodule

//--- logic/complexFirCore.sv
`timescale 1ns/10ps

module complexFirCore (
	input logic clock,
	input logic reset,
	input logic loadEnable,
	input logic coeffValid,
	input logic signed [complexFirPkg::coeffWidth-1:0] coeffRe,
	input logic signed [complexFirPkg::coeffWidth-1:0] coeffIm,
	input logic coeffSetFlag,
	input logic sampleStrobe,
	input logic signed [complexFirPkg::sampleWidth-1:0] sampleRe,
	input logic signed [complexFirPkg::sampleWidth-1:0] sampleIm,
	output logic busy,
	output logic resultValid,
	output logic signed [complexFirPkg::accWidth-1:0] resultRe,
	output logic signed [complexFirPkg::accWidth-1:0] resultIm
);

	complexFirPkg::coreState state;

	// Coefficient shift register, filled from the top so entry 0 ends up in slot 0.
	logic signed [complexFirPkg::coeffWidth-1:0] coeffReRegs [complexFirPkg::tapCount];
	logic signed [complexFirPkg::coeffWidth-1:0] coeffImRegs [complexFirPkg::tapCount];

	// Sample delay line; slot 0 holds the newest sample.
	logic signed [complexFirPkg::sampleWidth-1:0] lineRe [complexFirPkg::tapCount];
	logic signed [complexFirPkg::sampleWidth-1:0] lineIm [complexFirPkg::tapCount];

	// Tap being multiplied in this MAC cycle.
	logic [complexFirPkg::tapIndexWidth-1:0] tapIndex;

	// Running complex sum.
	logic signed [complexFirPkg::accWidth-1:0] accRe;
	logic signed [complexFirPkg::accWidth-1:0] accIm;

	// The four real products of one complex multiply.
	logic signed [complexFirPkg::productWidth-1:0] prodReRe;
	logic signed [complexFirPkg::productWidth-1:0] prodImIm;
	logic signed [complexFirPkg::productWidth-1:0] prodReIm;
	logic signed [complexFirPkg::productWidth-1:0] prodImRe;

	// One complex term and the accumulator after adding it.
	logic signed [complexFirPkg::accWidth-1:0] termRe;
	logic signed [complexFirPkg::accWidth-1:0] termIm;
	logic signed [complexFirPkg::accWidth-1:0] nextAccRe;
	logic signed [complexFirPkg::accWidth-1:0] nextAccIm;

	logic loadStart;
	logic sampleAccept;
	logic lastTap;

	// The core is only ever empty while the enable was low, so this catches each rising edge.
	assign loadStart = (state == complexFirPkg::stateEmpty) && loadEnable;

	// Done counts as idle, so back-to-back samples need no extra cycle.
	assign sampleAccept = sampleStrobe && loadEnable &&
		((state == complexFirPkg::stateIdle) || (state == complexFirPkg::stateDone));

	assign lastTap = (state == complexFirPkg::stateMac) &&
		(tapIndex == complexFirPkg::tapIndexWidth'(complexFirPkg::tapCount - 1));

	assign busy = (state == complexFirPkg::stateMac);

	// (c_re + j c_im)(x_re + j x_im); the operands are sign-extended to the product width first.
	assign prodReRe = complexFirPkg::productWidth'(coeffReRegs[tapIndex]) *
		complexFirPkg::productWidth'(lineRe[tapIndex]);
	assign prodImIm = complexFirPkg::productWidth'(coeffImRegs[tapIndex]) *
		complexFirPkg::productWidth'(lineIm[tapIndex]);
	assign prodReIm = complexFirPkg::productWidth'(coeffReRegs[tapIndex]) *
		complexFirPkg::productWidth'(lineIm[tapIndex]);
	assign prodImRe = complexFirPkg::productWidth'(coeffImRegs[tapIndex]) *
		complexFirPkg::productWidth'(lineRe[tapIndex]);

	assign termRe = complexFirPkg::accWidth'(prodReRe) - complexFirPkg::accWidth'(prodImIm);
	assign termIm = complexFirPkg::accWidth'(prodReIm) + complexFirPkg::accWidth'(prodImRe);
	assign nextAccRe = accRe + termRe;
	assign nextAccIm = accIm + termIm;

	// Control FSM.
	// A low enable sends the core back to empty from any state, in step with the loader flag.
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= complexFirPkg::stateEmpty;
		end else if (!loadEnable) begin
			state <= complexFirPkg::stateEmpty;
		end else begin
			case (state)
				complexFirPkg::stateEmpty: begin
					state <= complexFirPkg::stateLoading;
				end
				complexFirPkg::stateLoading: begin
					if (coeffSetFlag) begin
						state <= complexFirPkg::stateIdle;
					end
				end
				complexFirPkg::stateIdle, complexFirPkg::stateDone: begin
					if (sampleAccept) begin
						state <= complexFirPkg::stateMac;
					end
				end
				complexFirPkg::stateMac: begin
					if (lastTap) begin
						state <= complexFirPkg::stateDone;
					end
				end
				default: begin
					state <= complexFirPkg::stateEmpty;
				end
			endcase
		end
	end

	// Each loader entry shifts in at the top.
	always_ff @(posedge clock) begin
		if (coeffValid) begin
			for (int i = 0; i < complexFirPkg::tapCount - 1; i++) begin
				coeffReRegs[i] <= coeffReRegs[i + 1];
				coeffImRegs[i] <= coeffImRegs[i + 1];
			end
			coeffReRegs[complexFirPkg::tapCount - 1] <= coeffRe;
			coeffImRegs[complexFirPkg::tapCount - 1] <= coeffIm;
		end
	end

	// A new load empties the history.
	// An accepted sample pushes the line one slot down.
	always_ff @(posedge clock) begin
		if (loadStart) begin
			for (int i = 0; i < complexFirPkg::tapCount; i++) begin
				lineRe[i] <= '0;
				lineIm[i] <= '0;
			end
		end else if (sampleAccept) begin
			for (int i = 1; i < complexFirPkg::tapCount; i++) begin
				lineRe[i] <= lineRe[i - 1];
				lineIm[i] <= lineIm[i - 1];
			end
			lineRe[0] <= sampleRe;
			lineIm[0] <= sampleIm;
		end
	end

	// The accumulator starts from zero for every sample and adds one tap per MAC cycle.
	always_ff @(posedge clock) begin
		if (sampleAccept) begin
			accRe <= '0;
			accIm <= '0;
		end else if (busy) begin
			accRe <= nextAccRe;
			accIm <= nextAccIm;
		end
	end

	// Tap walk and result capture.
	// The result lands on the same edge on which busy falls.
	always_ff @(posedge clock) begin
		if (reset) begin
			tapIndex <= '0;
			resultValid <= 1'b0;
			resultRe <= '0;
			resultIm <= '0;
		end else if (sampleAccept) begin
			tapIndex <= '0;
			resultValid <= 1'b0;
		end else if (busy) begin
			tapIndex <= tapIndex + 1'b1;
			if (lastTap) begin
				resultRe <= nextAccRe;
				resultIm <= nextAccIm;
				resultValid <= 1'b1;
			end
		end
	end

endmodule

//--- logic/firCoeffLoader.sv
`timescale 1ns/10ps

module firCoeffLoader (
	input logic clock,
	input logic reset,
	input logic loadEnable,
	output logic coeffValid,
	output logic signed [complexFirPkg::coeffWidth-1:0] coeffRe,
	output logic signed [complexFirPkg::coeffWidth-1:0] coeffIm,
	output logic coeffSetFlag
);

	// Index of the next table entry to send.
	// It stops at tapCount, which marks the table as fully sent.
	logic [complexFirPkg::tapIndexWidth-1:0] tapCounter;

	// True while entries are still left to send.
	logic entriesLeft;

	assign entriesLeft = tapCounter < complexFirPkg::tapIndexWidth'(complexFirPkg::tapCount);

	always_ff @(posedge clock) begin
		if (reset) begin
			tapCounter <= '0;
			coeffValid <= 1'b0;
			coeffRe <= '0;
			coeffIm <= '0;
			coeffSetFlag <= 1'b0;
		end else if (loadEnable) begin
			if (entriesLeft) begin
				// Present entry k in the k-th cycle after the enable was first seen.
				coeffRe <= complexFirPkg::coeffTableRe[tapCounter];
				coeffIm <= complexFirPkg::coeffTableIm[tapCounter];
				coeffValid <= 1'b1;
				tapCounter <= tapCounter + 1'b1;
			end else begin
				// The last entry went out in the previous cycle.
				// The flag then holds for as long as the enable stays high.
				coeffValid <= 1'b0;
				coeffSetFlag <= 1'b1;
			end
		end else begin
			// A low enable clears everything.
			// The next rising edge therefore restarts the load from entry 0.
			tapCounter <= '0;
			coeffValid <= 1'b0;
			coeffRe <= '0;
			coeffIm <= '0;
			coeffSetFlag <= 1'b0;
		end
	end

endmodule

//--- logic/complexFirPkg.sv
package complexFirPkg;

	// Number of taps in the filter, and the counter width that can also hold tapCount itself.
	localparam int tapCount = 12;
	localparam int tapIndexWidth = $clog2(tapCount + 1);

	// Sample and coefficient parts are signed two's complement.
	localparam int sampleWidth = 8;
	localparam int coeffWidth = 8;

	// One real product of a coefficient part and a sample part.
	localparam int productWidth = sampleWidth + coeffWidth;

	// A 16-bit product, one bit for the sum of two products, four bits of growth over twelve taps.
	localparam int accWidth = 21;

	// Wishbone data width and word address width.
	localparam int busWidth = 32;
	localparam int addrWidth = 3;

	// Fixed complex coefficient table, entry 0 belongs to the newest sample.
	localparam logic signed [coeffWidth-1:0] coeffTableRe [tapCount] = '{
		8'sd3, 8'sd2, 8'sd17, 8'sd0, 8'sd55, 8'sd120,
		8'sd123, 8'sd56, -8'sd99, -8'sd109, 8'sd23, -8'sd60
	};
	localparam logic signed [coeffWidth-1:0] coeffTableIm [tapCount] = '{
		8'sd7, 8'sd0, 8'sd5, -8'sd3, -8'sd103, -8'sd111,
		-8'sd24, 8'sd96, -8'sd32, -8'sd76, -8'sd14, 8'sd10
	};

	// Register word addresses on the bus.
	localparam logic [addrWidth-1:0] regControl = 3'd0;
	localparam logic [addrWidth-1:0] regStatus = 3'd1;
	localparam logic [addrWidth-1:0] regSample = 3'd2;
	localparam logic [addrWidth-1:0] regResultRe = 3'd3;
	localparam logic [addrWidth-1:0] regResultIm = 3'd4;

	// Core control states.
	typedef enum logic [2:0] {
		stateEmpty,
		stateLoading,
		stateIdle,
		stateMac,
		stateDone
	} coreState;

endpackage
